// ==== src/system86_pkg.sv ====
`default_nettype none

package system86_pkg;

	////////////////////
	// Raster geometry
	////////////////////

	// Horizontal, in pixels
	localparam int H_TOTAL      = 384;
	localparam int H_ACTIVE     = 288;
	localparam int H_SYNC_START = 304;
	localparam int H_SYNC_END   = 336;

	// Vertical, in lines
	localparam int V_TOTAL      = 264;
	localparam int V_ACTIVE     = 224;
	localparam int V_SYNC_START = 232;
	localparam int V_SYNC_END   = 236;

	// 48 MHz master down to 6 MHz pixel
	localparam int PIX_DIV = 8;
	localparam int COUNT_W = 10;

	////////////////////
	// Test pattern
	////////////////////

	localparam int DOT_LSB_STEP = 228;
	localparam int DOT_MSB_STEP = 590;
	localparam int ACC_W        = 16;
	// Row where the palette bank flips and the row gradient restarts
	localparam int BANK_ROW     = 112;
	// Dot index split, high accumulator bits above low accumulator bits
	localparam int DOT_HI_W     = 3;
	localparam int DOT_LO_W     = 5;

	////////////////////
	// Colour and palette
	////////////////////

	localparam int DOT_W      = DOT_HI_W + DOT_LO_W;
	localparam int COLOR_W    = 4;
	localparam int PAL_ADDR_W = DOT_W + 1;		// bank, then dot
	localparam int PAL_DATA_W = 3 * COLOR_W;	// R, G, B nibbles, red on top
	localparam int VID_DEPTH  = 8;
	// Pixel enables between raw timing and colour out
	localparam int PIPE_PIX   = 2;

	// Horizontal region of the timing generator
	typedef enum logic [1:0] {
		H_ACT,
		H_FRONT,
		H_SYNC,
		H_BACK
	} h_region_e;

endpackage

`default_nettype wire

// ==== src/video_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_timing import system86_pkg::*; (
	input  logic i_clk,
	input  logic i_reset,
	output logic o_pix_ce,
	output logic o_hsync_n,
	output logic o_vsync_n,
	output logic o_hblank_n,
	output logic o_vblank_n
);

	localparam int DIV_W = $clog2(PIX_DIV);

	logic [DIV_W-1:0]   div;
	logic [COUNT_W-1:0] hcount;
	logic [COUNT_W-1:0] vcount;
	logic [COUNT_W-1:0] h_next;
	logic [COUNT_W-1:0] v_next;
	logic               h_wrap;
	h_region_e          h_region;
	h_region_e          region_next;
	logic               vsync_n_r;
	logic               vblank_n_r;

	////////////////////
	// Pixel enable
	////////////////////

	// Free running divider with the enable on its last count
	always_ff @(posedge i_clk) begin
		if (i_reset)
			div <= '0;
		else
			div <= div + 1'b1;
	end

	assign o_pix_ce = (div == DIV_W'(PIX_DIV - 1));

	////////////////////
	// Raster counters
	////////////////////

	// Position of the pixel that starts at the next enable
	assign h_wrap = (hcount == COUNT_W'(H_TOTAL - 1));
	assign h_next = h_wrap ? '0 : hcount + 1'b1;

	always_comb begin
		v_next = vcount;
		if (h_wrap) begin
			if (vcount == COUNT_W'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = vcount + 1'b1;
		end
	end

	// Region of the next pixel
	always_comb begin
		if (h_next < COUNT_W'(H_ACTIVE))
			region_next = H_ACT;
		else if (h_next < COUNT_W'(H_SYNC_START))
			region_next = H_FRONT;
		else if (h_next < COUNT_W'(H_SYNC_END))
			region_next = H_SYNC;
		else
			region_next = H_BACK;
	end

	// Reset parks on the last pixel of the frame so the first enable lands on 0,0
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			hcount     <= COUNT_W'(H_TOTAL - 1);
			vcount     <= COUNT_W'(V_TOTAL - 1);
			h_region   <= H_BACK;
			vsync_n_r  <= 1'b1;
			vblank_n_r <= 1'b0;
		end else if (o_pix_ce) begin
			hcount    <= h_next;
			vcount    <= v_next;
			h_region  <= region_next;
			// Vertical levels straight from line compares
			vsync_n_r  <= !((v_next >= COUNT_W'(V_SYNC_START)) &&
				(v_next < COUNT_W'(V_SYNC_END)));
			vblank_n_r <= (v_next < COUNT_W'(V_ACTIVE));
		end
	end

	// Horizontal levels decoded from the region register
	assign o_hblank_n = (h_region == H_ACT);
	assign o_hsync_n  = (h_region != H_SYNC);
	assign o_vsync_n  = vsync_n_r;
	assign o_vblank_n = vblank_n_r;

	// Sync pulse sits wholly inside the blanked columns
	assert property (@(posedge i_clk) disable iff (i_reset)
		!o_hsync_n |-> (hcount >= COUNT_W'(H_ACTIVE)));

endmodule

`default_nettype wire

// ==== src/blanking_to_count.sv ====
`timescale 1ns/10ps
`default_nettype none

module blanking_to_count import system86_pkg::*; (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_pix_ce,
	input  logic               i_hblank_n,
	input  logic               i_vblank_n,
	output logic               o_active,
	output logic [COUNT_W-1:0] o_col,
	output logic [COUNT_W-1:0] o_row
);

	logic               hblank_n_q;
	logic               vblank_n_q;
	logic               h_rise;
	logic               v_rise;
	logic [COUNT_W-1:0] col_q;
	logic [COUNT_W-1:0] row_q;

	////////////////////
	// Edge detect
	////////////////////

	// Blank levels of the previous pixel
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			hblank_n_q <= 1'b0;
			vblank_n_q <= 1'b0;
		end else if (i_pix_ce) begin
			hblank_n_q <= i_hblank_n;
			vblank_n_q <= i_vblank_n;
		end
	end

	// Start of active line, start of active frame
	assign h_rise = i_hblank_n && !hblank_n_q;
	assign v_rise = i_vblank_n && !vblank_n_q;

	////////////////////
	// Column and row
	////////////////////

	// Counts for the current pixel, no extra delay
	assign o_col = h_rise ? '0 : col_q + 1'b1;

	always_comb begin
		if (v_rise)
			o_row = '0;
		else if (h_rise)
			o_row = row_q + 1'b1;
		else
			o_row = row_q;
	end

	// Hold counts of this pixel for the next one
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			col_q <= '0;
			row_q <= '0;
		end else if (i_pix_ce) begin
			col_q <= o_col;
			row_q <= o_row;
		end
	end

	assign o_active = i_hblank_n && i_vblank_n;

	// Active area never runs past the visible window
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_active |-> (o_col < COUNT_W'(H_ACTIVE)) && (o_row < COUNT_W'(V_ACTIVE)));

endmodule

`default_nettype wire

// ==== src/dot_pattern_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module dot_pattern_gen import system86_pkg::*; (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_pix_ce,
	input  logic               i_active,
	input  logic [COUNT_W-1:0] i_col,
	input  logic [COUNT_W-1:0] i_row,
	output logic [DOT_W-1:0]   o_dot,
	output logic               o_bank
);

	logic [ACC_W-1:0] lsb_acc;
	logic [ACC_W-1:0] msb_acc;
	logic [DOT_W-1:0] dot_raw;
	logic             row_zero;
	logic             row_bank;

	// Index from accumulators before this pixel's step
	assign dot_raw  = {msb_acc[ACC_W-1 -: DOT_HI_W], lsb_acc[ACC_W-1 -: DOT_LO_W]};
	assign row_zero = (i_row == '0);
	assign row_bank = (i_row == COUNT_W'(BANK_ROW));

	////////////////////
	// Gradient
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			lsb_acc <= '0;
			msb_acc <= '0;
			o_dot   <= '0;
			o_bank  <= 1'b0;
		end else if (i_pix_ce) begin
			// Blanked pixels carry index 0
			o_dot <= i_active ? dot_raw : '0;

			// Upper bank for the lower half of the screen
			if (row_bank)
				o_bank <= 1'b1;
			else if (row_zero)
				o_bank <= 1'b0;

			if (i_col == '0) begin
				// Line start, column ramp restarts
				lsb_acc <= '0;
				// Row ramp restarts at top and at the bank split
				if (row_zero || row_bank)
					msb_acc <= '0;
				else
					msb_acc <= msb_acc + ACC_W'(DOT_MSB_STEP);
			end else begin
				lsb_acc <= lsb_acc + ACC_W'(DOT_LSB_STEP);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/palette_lookup.sv ====
`timescale 1ns/10ps
`default_nettype none

module palette_lookup import system86_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_pix_ce,
	input  logic [DOT_W-1:0]      i_dot,
	input  logic                  i_bank,
	input  logic                  i_hsync_n,
	input  logic                  i_vsync_n,
	input  logic                  i_hblank_n,
	input  logic                  i_vblank_n,
	input  logic                  i_pal_we,
	input  logic [PAL_ADDR_W-1:0] i_pal_addr,
	input  logic [PAL_DATA_W-1:0] i_pal_data,
	output logic [COLOR_W-1:0]    o_red,
	output logic [COLOR_W-1:0]    o_green,
	output logic [COLOR_W-1:0]    o_blue,
	output logic                  o_csync_n,
	output logic                  o_hsync_n,
	output logic                  o_vsync_n,
	output logic                  o_hblank_n,
	output logic                  o_vblank_n
);

	localparam int PAL_DEPTH = 1 << PAL_ADDR_W;

	logic [PAL_DATA_W-1:0] pal_mem [0:PAL_DEPTH-1];
	logic [PAL_ADDR_W-1:0] rd_addr;
	logic [PAL_DATA_W-1:0] rgb_q;
	// Index 0 is one pixel late, top index lines up with the colour
	logic [PIPE_PIX-1:0]   hsync_d;
	logic [PIPE_PIX-1:0]   vsync_d;
	logic [PIPE_PIX-1:0]   hblank_d;
	logic [PIPE_PIX-1:0]   vblank_d;

	////////////////////
	// Palette RAM
	////////////////////

	// Write on any clock, reads in the same cycle see old data
	always_ff @(posedge i_clk) begin
		if (i_pal_we)
			pal_mem[i_pal_addr] <= i_pal_data;
	end

	assign rd_addr = {i_bank, i_dot};

	////////////////////
	// Colour and sync pipe
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			hsync_d  <= '1;
			vsync_d  <= '1;
			hblank_d <= '0;
			vblank_d <= '0;
			rgb_q    <= '0;
		end else if (i_pix_ce) begin
			hsync_d  <= {hsync_d[PIPE_PIX-2:0], i_hsync_n};
			vsync_d  <= {vsync_d[PIPE_PIX-2:0], i_vsync_n};
			hblank_d <= {hblank_d[PIPE_PIX-2:0], i_hblank_n};
			vblank_d <= {vblank_d[PIPE_PIX-2:0], i_vblank_n};
			// Stage 0 blanks belong to the same pixel as the dot
			if (hblank_d[0] && vblank_d[0])
				rgb_q <= pal_mem[rd_addr];
			else
				rgb_q <= '0;
		end
	end

	// Red in the top nibble
	assign o_red   = rgb_q[3*COLOR_W-1 -: COLOR_W];
	assign o_green = rgb_q[2*COLOR_W-1 -: COLOR_W];
	assign o_blue  = rgb_q[COLOR_W-1 -: COLOR_W];

	assign o_hsync_n  = hsync_d[PIPE_PIX-1];
	assign o_vsync_n  = vsync_d[PIPE_PIX-1];
	assign o_hblank_n = hblank_d[PIPE_PIX-1];
	assign o_vblank_n = vblank_d[PIPE_PIX-1];
	// Composite low on either sync
	assign o_csync_n  = o_hsync_n && o_vsync_n;

	// No write lands on an unknown location
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_pal_we |-> !$isunknown(i_pal_addr));

endmodule

`default_nettype wire

// ==== src/system86.sv ====
`timescale 1ns/10ps
`default_nettype none

module system86 import system86_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_reset,

	// Palette write port
	input  logic                  i_pal_we,
	input  logic [PAL_ADDR_W-1:0] i_pal_addr,
	input  logic [PAL_DATA_W-1:0] i_pal_data,

	// Video timing
	output logic                  o_pix_ce,
	output logic                  o_hsync_n,
	output logic                  o_vsync_n,
	output logic                  o_hblank_n,
	output logic                  o_vblank_n,
	output logic                  o_csync_n,

	// Native 4 bit colour
	output logic [COLOR_W-1:0]    o_red,
	output logic [COLOR_W-1:0]    o_green,
	output logic [COLOR_W-1:0]    o_blue,

	// Extended colour
	output logic [VID_DEPTH-1:0]  o_vid_red,
	output logic [VID_DEPTH-1:0]  o_vid_green,
	output logic [VID_DEPTH-1:0]  o_vid_blue
);

	// Raw timing, current pixel
	logic               pix_ce;
	logic               hsync_n;
	logic               vsync_n;
	logic               hblank_n;
	logic               vblank_n;
	// Rebuilt position
	logic               active;
	logic [COUNT_W-1:0] col;
	logic [COUNT_W-1:0] row;
	// Pattern, one pixel behind
	logic [DOT_W-1:0]   dot;
	logic               bank;

	////////////////////
	// Video path
	////////////////////

	video_timing video_timing_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.o_pix_ce   (pix_ce),
		.o_hsync_n  (hsync_n),
		.o_vsync_n  (vsync_n),
		.o_hblank_n (hblank_n),
		.o_vblank_n (vblank_n)
	);

	blanking_to_count blanking_to_count_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_pix_ce   (pix_ce),
		.i_hblank_n (hblank_n),
		.i_vblank_n (vblank_n),
		.o_active   (active),
		.o_col      (col),
		.o_row      (row)
	);

	// Stands in for the tile generator dot output
	dot_pattern_gen dot_pattern_gen_inst (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_pix_ce (pix_ce),
		.i_active (active),
		.i_col    (col),
		.i_row    (row),
		.o_dot    (dot),
		.o_bank   (bank)
	);

	palette_lookup palette_lookup_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_pix_ce   (pix_ce),
		.i_dot      (dot),
		.i_bank     (bank),
		.i_hsync_n  (hsync_n),
		.i_vsync_n  (vsync_n),
		.i_hblank_n (hblank_n),
		.i_vblank_n (vblank_n),
		.i_pal_we   (i_pal_we),
		.i_pal_addr (i_pal_addr),
		.i_pal_data (i_pal_data),
		.o_red      (o_red),
		.o_green    (o_green),
		.o_blue     (o_blue),
		.o_csync_n  (o_csync_n),
		.o_hsync_n  (o_hsync_n),
		.o_vsync_n  (o_vsync_n),
		.o_hblank_n (o_hblank_n),
		.o_vblank_n (o_vblank_n)
	);

	assign o_pix_ce = pix_ce;

	// Nibble repeated to fill the wide component, full scale stays full scale
	assign o_vid_red   = {(VID_DEPTH / COLOR_W){o_red}};
	assign o_vid_green = {(VID_DEPTH / COLOR_W){o_green}};
	assign o_vid_blue  = {(VID_DEPTH / COLOR_W){o_blue}};

endmodule

`default_nettype wire

// ==== sim/system86_checks.svh ====
`ifndef SYSTEM86_CHECKS_SVH
`define SYSTEM86_CHECKS_SVH

////////////////////
// Error counters
////////////////////

int    err_rgb;
int    err_count;
int    err_bit;
string test_name;

task automatic check_rgb(input string name, input logic [PAL_DATA_W-1:0] exp,
	input logic [PAL_DATA_W-1:0] act);
	if (act !== exp) begin
		err_rgb++;
		$display("[ERROR] %s %s: expected %03h, actual %03h at %0t",
			test_name, name, exp, act, $time);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		err_count++;
		$display("[ERROR] %s %s: expected %0d, actual %0d at %0t",
			test_name, name, exp, act, $time);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		err_bit++;
		$display("[ERROR] %s %s: expected %b, actual %b at %0t",
			test_name, name, exp, act, $time);
	end
endtask

////////////////////
// Reference model
////////////////////

logic [PAL_DATA_W-1:0] pal_model [0:(1 << PAL_ADDR_W)-1];
logic [ACC_W-1:0]      lsb_ref;
logic [ACC_W-1:0]      msb_ref;
logic                  bank_ref;

// Colour from the whole address, bank bit included
function automatic logic [PAL_DATA_W-1:0] pal_init_value(input int addr);
	return PAL_DATA_W'((addr * 1237 + 91) ^ (addr << 3));
endfunction

// Every bit flipped, so no entry keeps its old colour
function automatic logic [PAL_DATA_W-1:0] pal_rewrite_value(input int addr);
	return ~pal_init_value(addr);
endfunction

task automatic reset_model;
	lsb_ref  = '0;
	msb_ref  = '0;
	bank_ref = 1'b0;
endtask

// One pixel of the gradient rule, expected colour out
task automatic ref_pixel(input int col, input int row, input logic active,
	output logic [PAL_DATA_W-1:0] exp);
	logic [DOT_W-1:0] dot;
	// Index from accumulators before this pixel's step
	dot = active ? {msb_ref[ACC_W-1 -: DOT_HI_W], lsb_ref[ACC_W-1 -: DOT_LO_W]} : '0;
	if (row == BANK_ROW)
		bank_ref = 1'b1;
	else if (row == 0)
		bank_ref = 1'b0;
	exp = active ? pal_model[{bank_ref, dot}] : '0;
	if (col == 0) begin
		lsb_ref = '0;
		if (row == 0 || row == BANK_ROW)
			msb_ref = '0;
		else
			msb_ref = msb_ref + ACC_W'(DOT_MSB_STEP);
	end else begin
		lsb_ref = lsb_ref + ACC_W'(DOT_LSB_STEP);
	end
endtask

`endif

// ==== sim/system86_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module system86_tb import system86_pkg::*; ();

	localparam int CLK_PERIOD  = 4;
	localparam int FRAME_PIX   = H_TOTAL * V_TOTAL;
	// Three frames of pixels plus slack for palette load and resets
	localparam int WATCHDOG_NS = 3 * FRAME_PIX * PIX_DIV * CLK_PERIOD + 20_000;
	// Vertical blank line used for the upper bank rewrite
	localparam int REWRITE_ROW = 240;
	localparam int BANK_SIZE   = 1 << DOT_W;

	logic                  i_clk;
	logic                  i_reset;
	logic                  i_pal_we;
	logic [PAL_ADDR_W-1:0] i_pal_addr;
	logic [PAL_DATA_W-1:0] i_pal_data;
	logic                  o_pix_ce;
	logic                  o_hsync_n;
	logic                  o_vsync_n;
	logic                  o_hblank_n;
	logic                  o_vblank_n;
	logic                  o_csync_n;
	logic [COLOR_W-1:0]    o_red;
	logic [COLOR_W-1:0]    o_green;
	logic [COLOR_W-1:0]    o_blue;
	logic [VID_DEPTH-1:0]  o_vid_red;
	logic [VID_DEPTH-1:0]  o_vid_green;
	logic [VID_DEPTH-1:0]  o_vid_blue;

	`include "system86_checks.svh"

	// Position rebuilt from the output blanks
	int   col_out;
	int   row_out;
	logic prev_hb;
	logic prev_vb;
	logic started;
	int   active_seen;
	logic rewrite_armed;
	logic ce_seen;

	system86 system86_inst (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_pal_we    (i_pal_we),
		.i_pal_addr  (i_pal_addr),
		.i_pal_data  (i_pal_data),
		.o_pix_ce    (o_pix_ce),
		.o_hsync_n   (o_hsync_n),
		.o_vsync_n   (o_vsync_n),
		.o_hblank_n  (o_hblank_n),
		.o_vblank_n  (o_vblank_n),
		.o_csync_n   (o_csync_n),
		.o_red       (o_red),
		.o_green     (o_green),
		.o_blue      (o_blue),
		.o_vid_red   (o_vid_red),
		.o_vid_green (o_vid_green),
		.o_vid_blue  (o_vid_blue)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	////////////////////
	// Helpers
	////////////////////

	// Falling edge inside the last clock of an output pixel
	task automatic wait_pixel;
		int n;
		n = 0;
		do begin
			@(negedge i_clk);
			n++;
		end while (o_pix_ce !== 1'b1);
		// Enables one master divide apart
		if (ce_seen)
			check_count("pixel period", PIX_DIV, n);
		ce_seen = 1'b1;
	endtask

	task automatic clear_position;
		col_out = 0;
		row_out = 0;
		prev_hb = 1'b0;
		prev_vb = 1'b0;
		started = 1'b0;
		ce_seen = 1'b0;
	endtask

	task automatic apply_reset;
		@(negedge i_clk);
		i_reset = 1'b1;
		repeat (3) @(negedge i_clk);
		i_reset = 1'b0;
		reset_model();
		clear_position();
	endtask

	task automatic check_reset_levels(input string name);
		test_name = name;
		check_bit("pix_ce", 1'b0, o_pix_ce);
		check_bit("hsync_n", 1'b1, o_hsync_n);
		check_bit("vsync_n", 1'b1, o_vsync_n);
		check_bit("csync_n", 1'b1, o_csync_n);
		check_bit("hblank_n", 1'b0, o_hblank_n);
		check_bit("vblank_n", 1'b0, o_vblank_n);
		check_rgb("rgb", '0, {o_red, o_green, o_blue});
	endtask

	// Position, geometry and colour checks on one output pixel
	task automatic sample_pixel;
		logic                  h_rise;
		logic                  v_rise;
		logic                  active;
		logic                  exp_hs;
		logic                  exp_vs;
		logic [PAL_DATA_W-1:0] exp;
		wait_pixel();
		h_rise = o_hblank_n && !prev_hb;
		v_rise = o_vblank_n && !prev_vb;
		if (h_rise && started)
			check_count("line length", H_TOTAL, col_out + 1);
		if (v_rise && started)
			check_count("frame length", V_TOTAL, row_out + 1);
		if (h_rise)
			started = 1'b1;
		col_out = h_rise ? 0 : col_out + 1;
		if (v_rise)
			row_out = 0;
		else if (h_rise)
			row_out++;
		prev_hb = o_hblank_n;
		prev_vb = o_vblank_n;

		if (started) begin
			active = o_hblank_n && o_vblank_n;
			exp_hs = !(col_out >= H_SYNC_START && col_out < H_SYNC_END);
			exp_vs = !(row_out >= V_SYNC_START && row_out < V_SYNC_END);
			check_bit("hblank_n", col_out < H_ACTIVE, o_hblank_n);
			check_bit("hsync_n", exp_hs, o_hsync_n);
			check_bit("vblank_n", row_out < V_ACTIVE, o_vblank_n);
			check_bit("vsync_n", exp_vs, o_vsync_n);
			check_bit("csync_n", exp_hs && exp_vs, o_csync_n);
			ref_pixel(col_out, row_out, active, exp);
			if (active) begin
				check_rgb("pattern", exp, {o_red, o_green, o_blue});
				active_seen++;
			end else begin
				check_rgb("blanked", '0, {o_red, o_green, o_blue});
			end
			// Both halves carry the nibble
			check_rgb("extended upper", exp,
				{o_vid_red[7:4], o_vid_green[7:4], o_vid_blue[7:4]});
			check_rgb("extended lower", exp,
				{o_vid_red[3:0], o_vid_green[3:0], o_vid_blue[3:0]});
		end

		// Upper bank rewrite with one entry per pixel
		if (rewrite_armed && started && row_out == REWRITE_ROW) begin
			if (col_out < BANK_SIZE) begin
				i_pal_we   = 1'b1;
				i_pal_addr = {1'b1, DOT_W'(col_out)};
				i_pal_data = pal_rewrite_value(BANK_SIZE + col_out);
				pal_model[BANK_SIZE + col_out] = pal_rewrite_value(BANK_SIZE + col_out);
			end else begin
				i_pal_we      = 1'b0;
				rewrite_armed = 1'b0;
			end
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset_state;
		// Reset high since time zero
		@(negedge i_clk);
		check_reset_levels("reset held");
		repeat (2) @(negedge i_clk);
		check_reset_levels("reset held");
		i_reset = 1'b0;
		@(negedge i_clk);
		check_reset_levels("reset released");
	endtask

	task automatic load_palette;
		for (int a = 0; a < (1 << PAL_ADDR_W); a++) begin
			@(negedge i_clk);
			i_pal_we     = 1'b1;
			i_pal_addr   = PAL_ADDR_W'(a);
			i_pal_data   = pal_init_value(a);
			pal_model[a] = pal_init_value(a);
		end
		@(negedge i_clk);
		i_pal_we = 1'b0;
	endtask

	// First frame geometry and pattern with the upper bank rewritten in its blanking
	task automatic test_first_frame;
		test_name = "first frame";
		active_seen   = 0;
		rewrite_armed = 1'b1;
		do sample_pixel(); while (!started);
		repeat (FRAME_PIX - 1) sample_pixel();
		check_count("active pixels", H_ACTIVE * V_ACTIVE, active_seen);
		if (rewrite_armed) begin
			err_count++;
			$display("Upper bank rewrite never ran during vertical blanking");
		end
	endtask

	// Rows above the split keep bank 0 and rows below show the new bank 1
	task automatic test_rewrite_frame;
		test_name = "rewrite frame";
		active_seen = 0;
		repeat (FRAME_PIX) sample_pixel();
		check_count("active pixels", H_ACTIVE * V_ACTIVE, active_seen);
	endtask

	initial begin
		i_reset       = 1'b1;
		i_pal_we      = 1'b0;
		i_pal_addr    = '0;
		i_pal_data    = '0;
		err_rgb       = 0;
		err_count     = 0;
		err_bit       = 0;
		rewrite_armed = 1'b0;
		active_seen   = 0;
		test_name     = "setup";
		clear_position();
		reset_model();

		test_reset_state();
		load_palette();
		apply_reset();
		test_first_frame();
		test_rewrite_frame();

		$display("Errors: rgb %0d, count %0d, bit %0d", err_rgb, err_count, err_bit);
		if (err_rgb + err_count + err_bit == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== system86.f ====
+incdir+sim
src/system86_pkg.sv
src/video_timing.sv
src/blanking_to_count.sv
src/dot_pattern_gen.sv
src/palette_lookup.sv
src/system86.sv
sim/system86_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FILELIST   = system86.f
TOP        = system86_tb
RTL_TOP    = system86
LOG        = sim.log
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
